// ==== rv_pkg.sv ====
package rv_pkg;

  // ##########################################################################
  // encodings
  // ##########################################################################

  typedef enum logic [6:0] {
    opc_op        = 7'b0110011,
    opc_op_imm    = 7'b0010011,
    opc_op_32     = 7'b0111011,
    opc_op_imm_32 = 7'b0011011,
    opc_lui       = 7'b0110111,
    opc_auipc     = 7'b0010111,
    opc_jal       = 7'b1101111,
    opc_jalr      = 7'b1100111,
    opc_branch    = 7'b1100011,
    opc_system    = 7'b1110011
  } opc_e;

  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
    alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
  } alu_op_e;

  // values follow funct3 of the branch instructions
  typedef enum logic [2:0] {
    br_beq  = 3'b000,
    br_bne  = 3'b001,
    br_blt  = 3'b100,
    br_bge  = 3'b101,
    br_bltu = 3'b110,
    br_bgeu = 3'b111
  } br_op_e;

  typedef enum logic [1:0] {
    wb_alu = 2'd0,
    wb_pc4 = 2'd1
  } wb_sel_e;

  typedef enum logic [2:0] {
    fmt_r, fmt_i, fmt_s, fmt_b, fmt_u, fmt_j
  } fmt_e;

  // ##########################################################################
  // instruction word with one view per format
  // ##########################################################################

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } rv_instr_u;

  // ##########################################################################
  // stage bundles
  // ##########################################################################

  typedef struct packed {
    rv_instr_u   instr;
    logic [63:0] pc;
    logic [63:0] snxt_pc;
    logic        execute_en;
  } fetch_t;

  typedef struct packed {
    logic [4:0]  index_rs1;
    logic [4:0]  index_rs2;
    logic [4:0]  index_rd;
    logic [63:0] pc;
    logic [63:0] snxt_pc;
    logic [63:0] gpr_data1;
    logic [63:0] gpr_data2;
    logic [63:0] imm;
    alu_op_e     alu_op;
    logic        alu_imm_en;
    logic        alu_pc_en;
    logic        alu_halfop;
    logic        branch_en;
    br_op_e      branch_op;
    logic        jump_en;
    logic        wb_en;
    wb_sel_e     wb_sel;
    logic        ebreak;
    logic        execute_en;
  } dec_t;

  typedef struct packed {
    logic        wb_en;
    logic [4:0]  index_rd;
    logic [63:0] data;
  } wb_t;

endpackage

// ==== rv_regfile.sv ====
`timescale 1ns/100ps

module rv_regfile (
  input  logic         clk,
  input  logic         rstn,
  input  logic [4:0]   index_rs1,
  input  logic [4:0]   index_rs2,
  output logic [63:0]  data_rs1,
  output logic [63:0]  data_rs2,
  input  rv_pkg::wb_t  wb
);

  // x0 has no storage
  logic [63:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.wb_en && wb.index_rd != 5'd0) begin
      regs[wb.index_rd] <= wb.data;
    end
  end

  assign data_rs1 = (index_rs1 == 5'd0) ? 64'd0 : regs[index_rs1];
  assign data_rs2 = (index_rs2 == 5'd0) ? 64'd0 : regs[index_rs2];

endmodule

// ==== rv_decoder.sv ====
`timescale 1ns/100ps

module rv_decoder (
  input  rv_pkg::rv_instr_u instr,
  output rv_pkg::fmt_e      fmt,
  output rv_pkg::alu_op_e   alu_op,
  output logic              alu_imm_en,
  output logic              alu_pc_en,
  output logic              alu_halfop,
  output logic              branch_en,
  output rv_pkg::br_op_e    branch_op,
  output logic              jump_en,
  output logic              wb_en,
  output rv_pkg::wb_sel_e   wb_sel,
  output logic              ebreak
);

  import rv_pkg::*;

  logic    reg_form;
  alu_op_e f3_op;

  // sub only exists in the register forms, bit 30 is immediate data otherwise
  assign reg_form = (instr.r_fmt.opcode == opc_op) || (instr.r_fmt.opcode == opc_op_32);

  always_comb begin
    case (instr.r_fmt.funct3)
      3'b000:  f3_op = (reg_form && instr.r_fmt.funct7[5]) ? alu_sub : alu_add;
      3'b001:  f3_op = alu_sll;
      3'b010:  f3_op = alu_slt;
      3'b011:  f3_op = alu_sltu;
      3'b100:  f3_op = alu_xor;
      3'b101:  f3_op = instr.r_fmt.funct7[5] ? alu_sra : alu_srl;
      3'b110:  f3_op = alu_or;
      default: f3_op = alu_and;
    endcase
  end

  always_comb begin
    fmt        = fmt_r;
    alu_op     = alu_add;
    alu_imm_en = 1'b0;
    alu_pc_en  = 1'b0;
    alu_halfop = 1'b0;
    branch_en  = 1'b0;
    branch_op  = br_op_e'(instr.b_fmt.funct3);
    jump_en    = 1'b0;
    wb_en      = 1'b0;
    wb_sel     = wb_alu;
    ebreak     = 1'b0;
    case (instr.r_fmt.opcode)
      opc_op: begin
        alu_op = f3_op;
        wb_en  = 1'b1;
      end
      opc_op_imm: begin
        fmt        = fmt_i;
        alu_op     = f3_op;
        alu_imm_en = 1'b1;
        wb_en      = 1'b1;
      end
      opc_op_32: begin
        alu_op     = f3_op;
        alu_halfop = 1'b1;
        wb_en      = 1'b1;
      end
      opc_op_imm_32: begin
        fmt        = fmt_i;
        alu_op     = f3_op;
        alu_imm_en = 1'b1;
        alu_halfop = 1'b1;
        wb_en      = 1'b1;
      end
      opc_lui: begin
        fmt        = fmt_u;
        alu_op     = alu_pass_b;
        alu_imm_en = 1'b1;
        wb_en      = 1'b1;
      end
      opc_auipc: begin
        fmt        = fmt_u;
        alu_imm_en = 1'b1;
        alu_pc_en  = 1'b1;
        wb_en      = 1'b1;
      end
      // jumps compute the target on the alu and write pc + 4
      opc_jal: begin
        fmt        = fmt_j;
        alu_imm_en = 1'b1;
        alu_pc_en  = 1'b1;
        jump_en    = 1'b1;
        wb_en      = 1'b1;
        wb_sel     = wb_pc4;
      end
      opc_jalr: begin
        fmt        = fmt_i;
        alu_imm_en = 1'b1;
        jump_en    = 1'b1;
        wb_en      = 1'b1;
        wb_sel     = wb_pc4;
      end
      opc_branch: begin
        fmt       = fmt_b;
        alu_op    = alu_sub;
        branch_en = 1'b1;
      end
      opc_system: begin
        fmt    = fmt_i;
        ebreak = (instr.i_fmt.funct3 == 3'b000) && (instr.i_fmt.imm_11_0 == 12'h001);
      end
      default: begin
        fmt = fmt_r;
      end
    endcase
  end

endmodule

// ==== rv_imm_gen.sv ====
`timescale 1ns/100ps

module rv_imm_gen (
  input  rv_pkg::rv_instr_u instr,
  input  rv_pkg::fmt_e      fmt,
  output logic [63:0]       imm
);

  import rv_pkg::*;

  always_comb begin
    case (fmt)
      fmt_i: imm = {{52{instr.i_fmt.imm_11_0[11]}}, instr.i_fmt.imm_11_0};
      fmt_s: imm = {{52{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
                    instr.s_fmt.imm_4_0};
      fmt_b: imm = {{51{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                    instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
      fmt_u: imm = {{32{instr.u_fmt.imm_31_12[19]}}, instr.u_fmt.imm_31_12, 12'd0};
      fmt_j: imm = {{43{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20, instr.j_fmt.imm_19_12,
                    instr.j_fmt.imm_11, instr.j_fmt.imm_10_1, 1'b0};
      // r format carries no immediate
      default: imm = 64'd0;
    endcase
  end

endmodule

// ==== rv_ifu.sv ====
`timescale 1ns/100ps

module rv_ifu #(
  parameter logic [63:0] reset_pc = 64'h0
) (
  input  logic              clk,
  input  logic              rstn,
  input  rv_pkg::rv_instr_u instr_in,
  input  logic              instr_valid,
  input  logic              flush,
  input  logic [63:0]       redirect_pc,
  output rv_pkg::fetch_t    fetch,
  output logic [63:0]       cur_pc
);

  logic [63:0] pc;

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      fetch.instr   <= instr_in;
      fetch.pc      <= pc;
      fetch.snxt_pc <= pc + 64'd4;
    end
    if (!rstn) begin
      pc               <= reset_pc;
      fetch.execute_en <= 1'b0;
    end else if (flush) begin
      // strobe in this cycle is dropped, fetch restarts at the target
      pc               <= redirect_pc;
      fetch.execute_en <= 1'b0;
    end else begin
      fetch.execute_en <= instr_valid;
      if (instr_valid) begin
        pc <= pc + 64'd4;
      end
    end
  end

  assign cur_pc = pc;

endmodule

// ==== rv_idu.sv ====
`timescale 1ns/100ps

module rv_idu (
  input  logic           clk,
  input  logic           rstn,
  input  rv_pkg::fetch_t fetch,
  input  logic           flush,
  input  rv_pkg::wb_t    wb,
  output rv_pkg::dec_t   dec
);

  import rv_pkg::*;

  logic [4:0]  index_rs1;
  logic [4:0]  index_rs2;
  logic [63:0] rf_data1;
  logic [63:0] rf_data2;
  logic [63:0] gpr_data1;
  logic [63:0] gpr_data2;
  logic [63:0] imm;
  logic        fwd1;
  logic        fwd2;

  fmt_e        fmt;
  alu_op_e     alu_op;
  logic        alu_imm_en;
  logic        alu_pc_en;
  logic        alu_halfop;
  logic        branch_en;
  br_op_e      branch_op;
  logic        jump_en;
  logic        wb_en;
  wb_sel_e     wb_sel;
  logic        ebreak;

  assign index_rs1 = fetch.instr.r_fmt.rs1;
  assign index_rs2 = fetch.instr.r_fmt.rs2;

  rv_regfile u_regfile (
    .clk       (clk),
    .rstn      (rstn),
    .index_rs1 (index_rs1),
    .index_rs2 (index_rs2),
    .data_rs1  (rf_data1),
    .data_rs2  (rf_data2),
    .wb        (wb)
  );

  // write-back lands in the regfile only at the next edge
  assign fwd1 = wb.wb_en && (wb.index_rd != 5'd0) && (wb.index_rd == index_rs1);
  assign fwd2 = wb.wb_en && (wb.index_rd != 5'd0) && (wb.index_rd == index_rs2);

  assign gpr_data1 = fwd1 ? wb.data : rf_data1;
  assign gpr_data2 = fwd2 ? wb.data : rf_data2;

  rv_decoder u_decoder (
    .instr      (fetch.instr),
    .fmt        (fmt),
    .alu_op     (alu_op),
    .alu_imm_en (alu_imm_en),
    .alu_pc_en  (alu_pc_en),
    .alu_halfop (alu_halfop),
    .branch_en  (branch_en),
    .branch_op  (branch_op),
    .jump_en    (jump_en),
    .wb_en      (wb_en),
    .wb_sel     (wb_sel),
    .ebreak     (ebreak)
  );

  rv_imm_gen u_imm_gen (
    .instr (fetch.instr),
    .fmt   (fmt),
    .imm   (imm)
  );

  // ##########################################################################
  // stage register
  // ##########################################################################

  always_ff @(posedge clk) begin
    dec.index_rs1  <= index_rs1;
    dec.index_rs2  <= index_rs2;
    dec.index_rd   <= fetch.instr.r_fmt.rd;
    dec.pc         <= fetch.pc;
    dec.snxt_pc    <= fetch.snxt_pc;
    dec.gpr_data1  <= gpr_data1;
    dec.gpr_data2  <= gpr_data2;
    dec.imm        <= imm;
    dec.alu_op     <= alu_op;
    dec.alu_imm_en <= alu_imm_en;
    dec.alu_pc_en  <= alu_pc_en;
    dec.alu_halfop <= alu_halfop;
    dec.branch_op  <= branch_op;
    dec.wb_sel     <= wb_sel;
    if (!rstn || flush) begin
      // squashed slot keeps its payload but does nothing downstream
      dec.execute_en <= 1'b0;
      dec.wb_en      <= 1'b0;
      dec.branch_en  <= 1'b0;
      dec.jump_en    <= 1'b0;
      dec.ebreak     <= 1'b0;
    end else begin
      dec.execute_en <= fetch.execute_en;
      dec.wb_en      <= wb_en;
      dec.branch_en  <= branch_en;
      dec.jump_en    <= jump_en;
      dec.ebreak     <= ebreak;
    end
  end

endmodule

// ==== rv_exu.sv ====
`timescale 1ns/100ps

module rv_exu (
  input  logic          clk,
  input  logic          rstn,
  input  rv_pkg::dec_t  dec,
  output rv_pkg::wb_t   wb,
  output logic          flush,
  output logic [63:0]   redirect_pc,
  output logic          halt
);

  import rv_pkg::*;

  logic [63:0] rs1_val;
  logic [63:0] rs2_val;
  logic [63:0] op_a;
  logic [63:0] op_b;
  logic [63:0] a_ext;
  logic [5:0]  shamt;
  logic [63:0] alu_res;
  logic [63:0] alu_out;
  logic [63:0] target;
  logic        taken;
  logic        run;
  logic        redirect;

  // bypass of the result registered one cycle ago
  assign rs1_val = (wb.wb_en && wb.index_rd != 5'd0 && wb.index_rd == dec.index_rs1) ?
                   wb.data : dec.gpr_data1;
  assign rs2_val = (wb.wb_en && wb.index_rd != 5'd0 && wb.index_rd == dec.index_rs2) ?
                   wb.data : dec.gpr_data2;

  assign op_a = dec.alu_pc_en  ? dec.pc  : rs1_val;
  assign op_b = dec.alu_imm_en ? dec.imm : rs2_val;

  // word ops shift only the low half, sra needs its sign in bit 63
  always_comb begin
    if (!dec.alu_halfop) begin
      a_ext = op_a;
    end else if (dec.alu_op == alu_sra) begin
      a_ext = {{32{op_a[31]}}, op_a[31:0]};
    end else begin
      a_ext = {32'd0, op_a[31:0]};
    end
  end

  assign shamt = dec.alu_halfop ? {1'b0, op_b[4:0]} : op_b[5:0];

  always_comb begin
    case (dec.alu_op)
      alu_add:    alu_res = a_ext + op_b;
      alu_sub:    alu_res = a_ext - op_b;
      alu_sll:    alu_res = a_ext << shamt;
      alu_slt:    alu_res = {63'd0, $signed(a_ext) < $signed(op_b)};
      alu_sltu:   alu_res = {63'd0, a_ext < op_b};
      alu_xor:    alu_res = a_ext ^ op_b;
      alu_srl:    alu_res = a_ext >> shamt;
      alu_sra:    alu_res = $unsigned($signed(a_ext) >>> shamt);
      alu_or:     alu_res = a_ext | op_b;
      alu_and:    alu_res = a_ext & op_b;
      alu_pass_b: alu_res = op_b;
      default:    alu_res = 64'd0;
    endcase
  end

  assign alu_out = dec.alu_halfop ? {{32{alu_res[31]}}, alu_res[31:0]} : alu_res;

  always_comb begin
    case (dec.branch_op)
      br_beq:  taken = (rs1_val == rs2_val);
      br_bne:  taken = (rs1_val != rs2_val);
      br_blt:  taken = ($signed(rs1_val) < $signed(rs2_val));
      br_bge:  taken = ($signed(rs1_val) >= $signed(rs2_val));
      br_bltu: taken = (rs1_val < rs2_val);
      br_bgeu: taken = (rs1_val >= rs2_val);
      default: taken = 1'b0;
    endcase
  end

  // the slot behind a redirect is younger and dies here
  assign run      = dec.execute_en && !flush;
  assign redirect = run && (dec.jump_en || (dec.branch_en && taken));
  assign target   = dec.jump_en ? {alu_res[63:1], 1'b0} : dec.pc + dec.imm;

  always_ff @(posedge clk) begin
    wb.index_rd <= dec.index_rd;
    wb.data     <= (dec.wb_sel == wb_pc4) ? dec.snxt_pc : alu_out;
    redirect_pc <= target;
    if (!rstn) begin
      wb.wb_en <= 1'b0;
      flush    <= 1'b0;
      halt     <= 1'b0;
    end else begin
      wb.wb_en <= run && dec.wb_en;
      flush    <= redirect;
      if (run && dec.ebreak) begin
        halt <= 1'b1;
      end
    end
  end

endmodule

// ==== rv_core.sv ====
`timescale 1ns/100ps

module rv_core #(
  parameter logic [63:0] reset_pc = 64'h0
) (
  input  logic         clk,
  input  logic         rstn,
  input  logic [31:0]  instr_in,
  input  logic         instr_valid,
  output rv_pkg::wb_t  wb,
  output logic         flush,
  output logic [63:0]  redirect_pc,
  output logic [63:0]  cur_pc,
  output logic         halt
);

  import rv_pkg::*;

  fetch_t fetch;
  dec_t   dec;

  rv_ifu #(
    .reset_pc (reset_pc)
  ) u_ifu (
    .clk         (clk),
    .rstn        (rstn),
    .instr_in    (instr_in),
    .instr_valid (instr_valid),
    .flush       (flush),
    .redirect_pc (redirect_pc),
    .fetch       (fetch),
    .cur_pc      (cur_pc)
  );

  // wb loops back into decode for the regfile write and forwarding
  rv_idu u_idu (
    .clk   (clk),
    .rstn  (rstn),
    .fetch (fetch),
    .flush (flush),
    .wb    (wb),
    .dec   (dec)
  );

  rv_exu u_exu (
    .clk         (clk),
    .rstn        (rstn),
    .dec         (dec),
    .wb          (wb),
    .flush       (flush),
    .redirect_pc (redirect_pc),
    .halt        (halt)
  );

endmodule

// ==== tb_rv_core.sv ====
`timescale 1ns/100ps

module tb_rv_core;

  import rv_pkg::*;

  localparam logic [63:0] start_pc  = 64'h1000;
  localparam int          max_words = 64;

  // what one instruction slot should show at the top level
  typedef struct packed {
    logic        wb_en;
    logic [4:0]  rd;
    logic [63:0] data;
    logic        flush;
    logic [63:0] target;
    logic        halt;
  } expect_t;

  logic        clk;
  logic        rstn;
  logic [31:0] instr_in;
  logic        instr_valid;
  wb_t         wb;
  logic        flush;
  logic [63:0] redirect_pc;
  logic [63:0] cur_pc;
  logic        halt;

  string       names [max_words];
  logic [31:0] words [max_words];
  expect_t     expv  [max_words];
  int          n_words = 0;
  int          pos = 0;

  // scoreboard in program order with the cycle each slot is due
  int          idx_q [$];
  int          due_q [$];

  int          cyc = 0;
  int          n_checks = 0;
  int          n_errors = 0;
  logic        checking = 1'b0;
  logic        halt_exp = 1'b0;

  rv_core #(
    .reset_pc (start_pc)
  ) u_rv_core (
    .clk         (clk),
    .rstn        (rstn),
    .instr_in    (instr_in),
    .instr_valid (instr_valid),
    .wb          (wb),
    .flush       (flush),
    .redirect_pc (redirect_pc),
    .cur_pc      (cur_pc),
    .halt        (halt)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic check_val(input string what, input logic [63:0] exp,
                           input logic [63:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("mismatch %s expected %h actual %h at %0t", what, exp, act, $time);
    end
  endtask

  task automatic load_program();
    int          fd;
    int          cnt;
    string       line;
    string       nm;
    logic [31:0] w;
    logic [63:0] f_wb;
    logic [63:0] f_rd;
    logic [63:0] f_data;
    logic [63:0] f_fl;
    logic [63:0] f_tgt;
    logic [63:0] f_halt;
    fd = $fopen("tb_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open tb_input.txt");
      n_errors++;
    end else begin
      while (!$feof(fd) && n_words < max_words) begin
        line = "";
        cnt = $fgets(line, fd);
        // blank lines and comment lines carry no word
        if (line.len() > 1 && line.getc(0) != "#") begin
          cnt = $sscanf(line, "%s %h %h %h %h %h %h %h",
                        nm, w, f_wb, f_rd, f_data, f_fl, f_tgt, f_halt);
          if (cnt != 8) begin
            $display("bad line in tb_input.txt: %s", line);
            n_errors++;
          end else begin
            names[n_words]        = nm;
            words[n_words]        = w;
            expv[n_words].wb_en   = f_wb[0];
            expv[n_words].rd      = f_rd[4:0];
            expv[n_words].data    = f_data;
            expv[n_words].flush   = f_fl[0];
            expv[n_words].target  = f_tgt;
            expv[n_words].halt    = f_halt[0];
            n_words++;
          end
        end
      end
      $fclose(fd);
      if (n_words == 0) begin
        $display("tb_input.txt holds no instructions");
        n_errors++;
      end
    end
  endtask

  // ##########################################################################
  // scoreboard sampled on the falling edge
  // ##########################################################################

  always @(negedge clk) begin : scoreboard
    int k;
    if (checking) begin
      if (due_q.size() > 0 && due_q[0] == cyc) begin
        k = idx_q.pop_front();
        void'(due_q.pop_front());
        check_val({names[k], " wb_en"}, expv[k].wb_en, wb.wb_en);
        if (expv[k].wb_en) begin
          check_val({names[k], " rd"}, expv[k].rd, wb.index_rd);
          check_val({names[k], " data"}, expv[k].data, wb.data);
        end
        check_val({names[k], " flush"}, expv[k].flush, flush);
        if (expv[k].flush) begin
          check_val({names[k], " redirect_pc"}, expv[k].target, redirect_pc);
        end
        if (expv[k].halt) begin
          halt_exp = 1'b1;
        end
      end else begin
        // nothing is due in this slot
        check_val("empty slot wb_en", 1'b0, wb.wb_en);
        check_val("empty slot flush", 1'b0, flush);
      end
      check_val("halt", halt_exp, halt);
    end
  end

  // ##########################################################################
  // stimulus
  // ##########################################################################

  initial begin : stimulus
    int burst;
    rstn        = 1'b0;
    instr_valid = 1'b0;
    instr_in    = '0;
    burst       = 0;
    void'($urandom(32));
    load_program();
    repeat (3) @(posedge clk);
    #1;
    rstn = 1'b1;
    check_val("reset wb_en", 1'b0, wb.wb_en);
    check_val("reset flush", 1'b0, flush);
    check_val("reset halt", 1'b0, halt);
    check_val("reset cur_pc", start_pc, cur_pc);
    checking = 1'b1;
    while (pos < n_words) begin
      instr_valid = 1'b0;
      // fetch drops a strobe while flush is high
      if (!flush && (burst > 0 || ($urandom % 4) != 0)) begin
        check_val({names[pos], " cur_pc"}, start_pc + 4 * pos, cur_pc);
        instr_in    = words[pos];
        instr_valid = 1'b1;
        idx_q.push_back(pos);
        due_q.push_back(cyc + 3);
        if (burst > 0) begin
          burst--;
        end
        // the two shadow words of a redirect go in back to back
        if (expv[pos].flush) begin
          burst = 2;
        end
        pos++;
      end
      @(posedge clk);
      #1;
    end
    instr_valid = 1'b0;
    while (due_q.size() > 0) begin
      @(posedge clk);
    end
    // halt has to hold with the pipeline empty
    repeat (4) @(posedge clk);
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // two cycles per word leave room for idles and flush gaps
  initial begin : watchdog
    wait (n_words > 0);
    #((n_words * 2 + 20) * 10);
    $display("run timed out with %0d of %0d words strobed", pos, n_words);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// ==== tb_input.txt ====
# name instr wb_en rd data flush redirect_target halt, all numbers in hex
# shadow words behind a taken branch or jump expect zero in every column
addi_x1 00500093 1 01 5 0 0 0
addi_x2_neg ffd00113 1 02 fffffffffffffffd 0 0 0
add_x3_fwd 002081b3 1 03 2 0 0 0
sub_x4_fwd 40118233 1 04 fffffffffffffffd 0 0 0
xori_x5 0f024293 1 05 ffffffffffffff0d 0 0 0
slt_x6 00122333 1 06 1 0 0 0
sltu_x7 001233b3 1 07 0 0 0 0
slli_x8 03c09413 1 08 5000000000000000 0 0 0
srai_x9 40425493 1 09 ffffffffffffffff 0 0 0
srli_x10 03c25513 1 0a f 0 0 0
or_x11 0080e5b3 1 0b 5000000000000005 0 0 0
andi_x12 7ff2f613 1 0c 70d 0 0 0
lui_x13 7ffff6b7 1 0d 7ffff000 0 0 0
addiw_x14 7ff6871b 1 0e 7ffff7ff 0 0 0
addw_x15 00e707bb 1 0f ffffffffffffeffe 0 0 0
subw_x16 4010083b 1 10 fffffffffffffffb 0 0 0
sraiw_x17 4047d89b 1 11 fffffffffffffeff 0 0 0
srlw_x18 00a7d93b 1 12 1ffff 0 0 0
sllw_x19 00a099bb 1 13 28000 0 0 0
addi_x0 00708013 1 00 c 0 0 0
add_x20_x0 00100a33 1 14 5 0 0 0
auipc_x21 00001a97 1 15 2054 0 0 0
beq_taken 01408663 0 00 0 1 1064 0
beq_shadow1 00100b13 0 00 0 0 0 0
beq_shadow2 00200b13 0 00 0 0 0 0
bne_not_taken 01409663 0 00 0 0 0 0
blt_taken 00124663 0 00 0 1 1074 0
blt_shadow1 00300b13 0 00 0 0 0 0
blt_shadow2 00400b13 0 00 0 0 0 0
bltu_not_taken 00126663 0 00 0 0 0 0
bge_taken 0040d663 0 00 0 1 1084 0
bge_shadow1 00100b93 0 00 0 0 0 0
bge_shadow2 00200b93 0 00 0 0 0 0
bgeu_not_taken 0040f663 0 00 0 0 0 0
addi_x23_x22 000b0b93 1 17 0 0 0 0
jal_x24 00c00c6f 1 18 1090 1 1098 0
jal_shadow1 00100c93 0 00 0 0 0 0
jal_shadow2 00200c93 0 00 0 0 0 0
jalr_x25 014c0ce7 1 19 109c 1 10a4 0
jalr_shadow1 00100d13 0 00 0 0 0 0
jalr_shadow2 00200d13 0 00 0 0 0 0
jalr_odd_x26 015c8d67 1 1a 10a8 1 10b0 0
jalr_odd_shadow1 00100d93 0 00 0 0 0 0
jalr_odd_shadow2 00200d93 0 00 0 0 0 0
add_x28 019d0e33 1 1c 2144 0 0 0
ebreak 00100073 0 00 0 0 0 1

// ==== src.f ====
rv_pkg.sv
rv_regfile.sv
rv_decoder.sv
rv_imm_gen.sv
rv_ifu.sv
rv_idu.sv
rv_exu.sv
rv_core.sv
tb_rv_core.sv
